/* compile.f */
+incdir+hw
hw/psgPkg.sv
hw/psgWaveChannels.sv
hw/psgBusArb.sv
hw/psgWaveMaster.sv
hw/psgWaveFetch.sv
testbench/psgWaveFetch_tb.sv

/* hw/psgBusArb.sv */
`timescale 1ns/100ps

`include "psg_cfg.svh"

module psgBusArb import psgPkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`PSG_NUM_CHAN-1:0] chanReq,
	input  logic                     done,
	output logic                     grantValid,
	output chanIdx_t                 grantChan
);

	logic     anyReq;
	chanIdx_t winner;

	// ==================================================
	// priority encoder
	// ==================================================

	// scan from the top so the lowest requester is left standing
	always_comb begin
		winner = '0;
		for (int i = `PSG_NUM_CHAN - 1; i >= 0; i--) begin
			if (chanReq[i]) begin
				winner = chanIdx_t'(i);
			end
		end
	end

	assign anyReq = |chanReq;

	// ==================================================
	// registered grant
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			grantValid <= 1'b0;
			grantChan  <= '0;
		end else if (grantValid) begin
			// owner keeps the bus until its read completes
			if (done) begin
				grantValid <= 1'b0;
			end
		end else if (anyReq) begin
			grantValid <= 1'b1;
			grantChan  <= winner;
		end
	end

	// dropping the grant on done forces one idle clock, which lets
	// the served channel clear its request before the next scan

endmodule

/* hw/psgPkg.sv */
`include "psg_cfg.svh"

package psgPkg;

	// ==================================================
	// shared types
	// ==================================================

	// channel number, wide enough for every wave table channel
	typedef logic [$clog2(`PSG_NUM_CHAN)-1:0] chanIdx_t;

	// bus master sequencing
	typedef enum logic {
		msIdle,
		msCycle
	} masterState_t;

endpackage

/* hw/psgWaveChannels.sv */
`timescale 1ns/100ps

`include "psg_cfg.svh"

module psgWaveChannels import psgPkg::*; (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         ce,
	input  logic                                         regWe,
	input  chanIdx_t                                     regChan,
	input  logic [`PSG_PHASE_W-1:0]                      regFreq,
	input  logic                                         done,
	input  chanIdx_t                                     doneChan,
	output logic [`PSG_NUM_CHAN-1:0]                     chanReq,
	output logic [`PSG_NUM_CHAN-1:0][`PSG_WAVE_AW-1:0]   chanAdr
);

	// width of the phase byte that indexes one channel's table
	localparam int ByteW = `PSG_WAVE_AW - $bits(chanIdx_t);

	// ==================================================
	// one accumulator per channel
	// ==================================================
	for (genvar i = 0; i < `PSG_NUM_CHAN; i++) begin : gChan
		logic [`PSG_PHASE_W-1:0] freq;
		logic [`PSG_PHASE_W-1:0] phase;
		logic [`PSG_PHASE_W-1:0] nextPhase;
		logic                    regHit;
		logic                    doneHit;
		logic                    topChange;

		assign nextPhase = phase + freq;
		assign regHit    = regWe && (regChan == chanIdx_t'(i));
		assign doneHit   = done && (doneChan == chanIdx_t'(i));

		// a new table entry is needed once the top byte moves
		assign topChange = ce &&
			(nextPhase[`PSG_PHASE_W-1 -: ByteW] != phase[`PSG_PHASE_W-1 -: ByteW]);

		always_ff @(posedge clk) begin
			if (rst) begin
				freq       <= '0;
				phase      <= '0;
				chanReq[i] <= 1'b0;
			end else if (regHit) begin
				// frequency write restarts the wave at entry zero
				freq       <= regFreq;
				phase      <= '0;
				chanReq[i] <= 1'b1;
			end else begin
				if (ce) begin
					phase <= nextPhase;
				end
				// a fresh byte on the done edge keeps the request alive
				if (topChange) begin
					chanReq[i] <= 1'b1;
				end else if (doneHit) begin
					chanReq[i] <= 1'b0;
				end
			end
		end

		// pending address, newest byte overwrites an unserved one
		always_ff @(posedge clk) begin
			if (regHit) begin
				chanAdr[i] <= {chanIdx_t'(i), {ByteW{1'b0}}};
			end else if (topChange) begin
				chanAdr[i] <= {chanIdx_t'(i), nextPhase[`PSG_PHASE_W-1 -: ByteW]};
			end
		end
	end

endmodule

/* hw/psgWaveFetch.sv */
`timescale 1ns/100ps

`include "psg_cfg.svh"

module psgWaveFetch import psgPkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ce,
	// frequency write port
	input  logic                     regWe,
	input  chanIdx_t                 regChan,
	input  logic [`PSG_PHASE_W-1:0]  regFreq,
	// wishbone master
	output logic                     wbCyc,
	output logic                     wbStb,
	output logic                     wbWe,
	output logic [`PSG_WAVE_AW-1:0]  wbAdr,
	input  logic [`PSG_DATA_W-1:0]   wbDatI,
	input  logic                     wbAck,
	// sample stream
	output logic                     smpValid,
	output chanIdx_t                 smpChan,
	output logic [`PSG_DATA_W-1:0]   smpData
);

	logic [`PSG_NUM_CHAN-1:0]                   chanReq;
	logic [`PSG_NUM_CHAN-1:0][`PSG_WAVE_AW-1:0] chanAdr;
	logic                                       grantValid;
	chanIdx_t                                   grantChan;
	logic                                       done;
	chanIdx_t                                   doneChan;

	// ==================================================
	// channels feed the arbiter, arbiter feeds the master
	// ==================================================
	psgWaveChannels uChannels (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.regWe    (regWe),
		.regChan  (regChan),
		.regFreq  (regFreq),
		.done     (done),
		.doneChan (doneChan),
		.chanReq  (chanReq),
		.chanAdr  (chanAdr)
	);

	psgBusArb uArb (
		.clk        (clk),
		.rst        (rst),
		.chanReq    (chanReq),
		.done       (done),
		.grantValid (grantValid),
		.grantChan  (grantChan)
	);

	// done closes the loop back to both the arbiter and the channels
	psgWaveMaster uMaster (
		.clk        (clk),
		.rst        (rst),
		.grantValid (grantValid),
		.grantChan  (grantChan),
		.chanAdr    (chanAdr),
		.wbDatI     (wbDatI),
		.wbAck      (wbAck),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.wbWe       (wbWe),
		.wbAdr      (wbAdr),
		.done       (done),
		.doneChan   (doneChan),
		.smpValid   (smpValid),
		.smpChan    (smpChan),
		.smpData    (smpData)
	);

endmodule

/* hw/psgWaveMaster.sv */
`timescale 1ns/100ps

`include "psg_cfg.svh"

module psgWaveMaster import psgPkg::*; (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         grantValid,
	input  chanIdx_t                                     grantChan,
	input  logic [`PSG_NUM_CHAN-1:0][`PSG_WAVE_AW-1:0]   chanAdr,
	input  logic [`PSG_DATA_W-1:0]                       wbDatI,
	input  logic                                         wbAck,
	output logic                                         wbCyc,
	output logic                                         wbStb,
	output logic                                         wbWe,
	output logic [`PSG_WAVE_AW-1:0]                      wbAdr,
	output logic                                         done,
	output chanIdx_t                                     doneChan,
	output logic                                         smpValid,
	output chanIdx_t                                     smpChan,
	output logic [`PSG_DATA_W-1:0]                       smpData
);

	masterState_t state;
	logic         startCyc;
	logic         endCyc;

	// the grant is still up on the clock after done, so skip it there
	assign startCyc = (state == msIdle) && grantValid && !done;
	assign endCyc   = (state == msCycle) && wbAck;

	// read only master
	assign wbWe = 1'b0;

	// ==================================================
	// bus cycle control
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= msIdle;
			wbCyc    <= 1'b0;
			wbStb    <= 1'b0;
			done     <= 1'b0;
			smpValid <= 1'b0;
		end else begin
			done     <= 1'b0;
			smpValid <= 1'b0;
			case (state)
				msIdle: begin
					if (startCyc) begin
						state <= msCycle;
						wbCyc <= 1'b1;
						wbStb <= 1'b1;
					end
				end
				msCycle: begin
					// wait states simply hold cyc and stb
					if (endCyc) begin
						state    <= msIdle;
						wbCyc    <= 1'b0;
						wbStb    <= 1'b0;
						done     <= 1'b1;
						smpValid <= 1'b1;
					end
				end
				default: state <= msIdle;
			endcase
		end
	end

	// ==================================================
	// address and sample capture
	// ==================================================
	always_ff @(posedge clk) begin
		if (startCyc) begin
			wbAdr <= chanAdr[grantChan];
		end
		if (endCyc) begin
			doneChan <= grantChan;
			smpChan  <= grantChan;
			smpData  <= wbDatI;
		end
	end

endmodule

/* hw/psg_cfg.svh */
`ifndef PSG_CFG_SVH
`define PSG_CFG_SVH

// ==================================================
// wave table fetch engine sizing
// ==================================================

// number of wave table channels
`define PSG_NUM_CHAN 8

// phase accumulator and frequency word width
`define PSG_PHASE_W 16

// wave table address is {channel, top phase byte}
`define PSG_WAVE_AW 11

// sample width returned by the wave table
`define PSG_DATA_W 12

`endif

/* testbench/psgWaveFetch_tb.sv */
`timescale 1ns/100ps

`include "psg_cfg.svh"

module psgWaveFetch_tb import psgPkg::*; ();

	localparam int ClkPeriod = 20;
	localparam int ByteW = `PSG_WAVE_AW - $bits(chanIdx_t);
	// clocks per test, reset included
	localparam int ResetLen = 40;
	localparam int SingleLen = 240;
	localparam int PriorityLen = 100;
	localparam int WaitLen = 140;
	localparam int OverrunLen = 260;
	localparam int WatchClocks = ResetLen + SingleLen + PriorityLen + WaitLen + OverrunLen + 200;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic ce = 1'b0;
	logic regWe = 1'b0;
	chanIdx_t regChan = '0;
	logic [`PSG_PHASE_W-1:0] regFreq = '0;
	logic wbCyc, wbStb, wbWe, wbAck = 1'b0;
	logic [`PSG_WAVE_AW-1:0] wbAdr;
	logic [`PSG_DATA_W-1:0] wbDatI = '0;
	logic smpValid;
	chanIdx_t smpChan;
	logic [`PSG_DATA_W-1:0] smpData;

	logic [31:0] lfsr = 32'he9b;
	int errors = 0;
	int checks = 0;
	int stallClocks = 0;
	int waitLeft;
	logic slaveBusy;
	logic heldLast;
	logic [`PSG_WAVE_AW-1:0] heldAdr;
	logic [`PSG_WAVE_AW-1:0] ackAdr;
	logic [`PSG_WAVE_AW-1:0] smpAdrQ[$];
	chanIdx_t smpChanQ[$];

	psgWaveFetch UUT (
		.clk(clk), .rst(rst), .ce(ce),
		.regWe(regWe), .regChan(regChan), .regFreq(regFreq),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatI(wbDatI), .wbAck(wbAck),
		.smpValid(smpValid), .smpChan(smpChan), .smpData(smpData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	// ==================================================
	// helpers
	// ==================================================

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic int drawBits(input int n);
		int v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = (v << 1) | fb;
		end
		return v;
	endfunction

	// wave table contents: address times 5 plus 3
	function automatic logic [`PSG_DATA_W-1:0] romWord(input logic [`PSG_WAVE_AW-1:0] adr);
		int v;
		v = adr * 5 + 3;
		return v[`PSG_DATA_W-1:0];
	endfunction

	function automatic logic [`PSG_WAVE_AW-1:0] tableAdr(input int ch, input int b);
		logic [`PSG_WAVE_AW-1:0] a;
		a = (ch << ByteW) | (b % (1 << ByteW));
		return a;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic resetDut();
		@(posedge clk);
		rst <= 1'b1;
		ce <= 1'b0;
		regWe <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		smpAdrQ.delete();
		smpChanQ.delete();
	endtask

	task automatic writeFreq(input int ch, input int f);
		@(posedge clk);
		regWe <= 1'b1;
		regChan <= chanIdx_t'(ch);
		regFreq <= f[`PSG_PHASE_W-1:0];
	endtask

	task automatic releaseWrite();
		@(posedge clk);
		regWe <= 1'b0;
	endtask

	task automatic waitSamples(input string name, input int n, input int limit);
		int cnt;
		cnt = 0;
		while (smpAdrQ.size() < n && cnt < limit) begin
			@(negedge clk);
			cnt++;
		end
		if (smpAdrQ.size() < n) begin
			errors++;
			$display("%s: only %0d of %0d samples arrived within %0d clocks",
				name, smpAdrQ.size(), n, limit);
		end
	endtask

	// ==================================================
	// wave table slave and bus monitor
	// ==================================================
	always @(posedge clk) begin
		if (rst) begin
			wbAck <= 1'b0;
			slaveBusy = 1'b0;
		end else if (wbAck) begin
			// master closes the cycle on this edge
			wbAck <= 1'b0;
			slaveBusy = 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!slaveBusy) begin
				slaveBusy = 1'b1;
				waitLeft = drawBits(2);
			end
			if (waitLeft == 0) begin
				wbAck <= 1'b1;
				wbDatI <= romWord(wbAdr);
			end else begin
				waitLeft = waitLeft - 1;
			end
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			heldLast = 1'b0;
		end else begin
			// a cycle without ack must hold cyc, stb and adr
			if (heldLast) begin
				checkValue("wait state wbCyc", 1, wbCyc);
				checkValue("wait state wbStb", 1, wbStb);
				checkValue("wait state wbAdr", heldAdr, wbAdr);
				if (!wbAck)
					stallClocks++;
			end
			if (wbCyc)
				checkValue("read only wbWe", 0, wbWe);
			if (wbCyc && wbStb && wbAck)
				ackAdr = wbAdr;
			if (smpValid) begin
				smpAdrQ.push_back(ackAdr);
				smpChanQ.push_back(smpChan);
				checkValue("sample data", romWord(ackAdr), smpData);
				checkValue("sample channel", ackAdr >> ByteW, smpChan);
			end
			heldLast = wbCyc && wbStb && !wbAck;
			heldAdr = wbAdr;
		end
	end

	// ==================================================
	// directed tests
	// ==================================================
	task automatic resetQuiet();
		resetDut();
		repeat (20) begin
			@(negedge clk);
			checkValue("reset wbCyc", 0, wbCyc);
			checkValue("reset wbStb", 0, wbStb);
			checkValue("reset smpValid", 0, smpValid);
		end
	endtask

	task automatic singleChannel();
		resetDut();
		writeFreq(3, 256);
		releaseWrite();
		waitSamples("single channel", 1, 40);
		// freq 256 moves the top byte by one per ce pulse
		for (int k = 1; k <= 4; k++) begin
			@(posedge clk);
			ce <= 1'b1;
			@(posedge clk);
			ce <= 1'b0;
			repeat (40) @(negedge clk);
			checkValue("single channel count", k + 1, smpAdrQ.size());
		end
		for (int i = 0; i < smpAdrQ.size(); i++) begin
			checkValue("single channel address", tableAdr(3, i), smpAdrQ[i]);
			checkValue("single channel smpChan", 3, smpChanQ[i]);
		end
	endtask

	task automatic priorityOrder();
		int order[4];
		order = '{7, 2, 5, 6};
		resetDut();
		// channel 7 holds the bus while 5, 2 and 6 queue up
		writeFreq(7, 16'h100);
		writeFreq(5, 16'h100);
		writeFreq(2, 16'h100);
		writeFreq(6, 16'h100);
		releaseWrite();
		waitSamples("priority", 4, 80);
		for (int i = 0; i < 4 && i < smpAdrQ.size(); i++) begin
			checkValue("priority smpChan", order[i], smpChanQ[i]);
			checkValue("priority address", tableAdr(order[i], 0), smpAdrQ[i]);
		end
	endtask

	task automatic waitStateHold();
		resetDut();
		stallClocks = 0;
		for (int ch = 0; ch < `PSG_NUM_CHAN; ch++)
			writeFreq(ch, 0);
		releaseWrite();
		waitSamples("wait states", `PSG_NUM_CHAN, 120);
		for (int i = 0; i < smpAdrQ.size(); i++) begin
			checkValue("wait states smpChan", i, smpChanQ[i]);
			checkValue("wait states address", tableAdr(i, 0), smpAdrQ[i]);
		end
		if (stallClocks == 0) begin
			errors++;
			$display("wait states: the slave never held off an acknowledge");
		end
	endtask

	task automatic ceGatingOverrun();
		int prev;
		int cur;
		resetDut();
		writeFreq(1, 512);
		releaseWrite();
		waitSamples("ce gating", 1, 40);
		repeat (50) @(negedge clk);
		checkValue("ce gating count", 1, smpAdrQ.size());
		// 100 ce clocks stay short of the phase wrap
		@(posedge clk);
		ce <= 1'b1;
		repeat (100) @(posedge clk);
		ce <= 1'b0;
		repeat (40) @(negedge clk);
		if (smpAdrQ.size() < 3) begin
			errors++;
			$display("overrun: only %0d samples served with ce high", smpAdrQ.size());
		end
		for (int i = 1; i < smpAdrQ.size(); i++) begin
			prev = smpAdrQ[i - 1][ByteW-1:0];
			cur = smpAdrQ[i][ByteW-1:0];
			checkValue("overrun smpChan", 1, smpChanQ[i]);
			if (cur <= prev || cur - prev < 2) begin
				errors++;
				$display("overrun: top byte %0d served after %0d", cur, prev);
			end
		end
	endtask

	// ==================================================
	// sequencing and watchdog
	// ==================================================
	initial begin
		resetQuiet();
		singleChannel();
		priorityOrder();
		waitStateHold();
		ceGatingOverrun();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(WatchClocks * ClkPeriod);
		$display("watchdog: run did not finish within %0d clocks", WatchClocks);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
